// ==== verilog/memMap_consts.svh ====
`ifndef MEMMAP_CONSTS_SVH
`define MEMMAP_CONSTS_SVH

// Memory map of the data RAM window

// First byte address seen by the processor
`define MEM_BASE 32'hBFC0_0000

// Window size in bytes
`define MEM_BYTES 32'd16384

// Bank geometry
// Words interleave across banks on address bits 3:2
`define NUM_BANKS 4

// log2 of NUM_BANKS
`define BANK_BITS 2

// Words held by one bank
`define BANK_WORDS 1024

// log2 of BANK_WORDS
`define WORD_BITS 10

// Bytes per word and lanes per bank
`define LANE_COUNT 4

`endif

// ==== verilog/memPkg.sv ====
`include "memMap_consts.svh"

package memPkg;

    // Master to slave signals of the Wishbone classic port
    typedef struct packed {
        logic        cyc;  // Bus cycle in progress
        logic        stb;  // Valid transfer
        logic        we;   // Write when high
        logic [31:0] adr;  // Byte address
        logic [31:0] dat;  // Write data
        logic [3:0]  sel;  // Byte lane selects
    } wbReqT;

    // Slave to master signals
    typedef struct packed {
        logic        ack;  // Normal termination
        logic        err;  // Error termination
        logic [31:0] dat;  // Read data, zero unless ack
    } wbRspT;

    // One access to a single bank
    typedef struct packed {
        logic                  en;        // Bank access this cycle
        logic                  we;        // Write access
        logic [`WORD_BITS-1:0] wordAddr;  // Word inside the bank
        logic [31:0]           data;      // Write data
        logic [3:0]            sel;       // Byte lanes to write
    } bankReqT;

    // Bank number
    typedef logic [`BANK_BITS-1:0] bankIdxT;

endpackage

// ==== verilog/wbBankDecoder.sv ====
`timescale 1ns/1ps
`include "memMap_consts.svh"

module wbBankDecoder import memPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  wbReqT   wbReq,
    output bankReqT bankReq [`NUM_BANKS],
    output logic    accepted,     // Good access taken last edge
    output logic    errPending,   // Bad access taken last edge
    output bankIdxT bankSel       // Bank of the last taken access
);

    logic [31:0]           offset;     // Address relative to window base
    logic                  inRange;
    logic                  aligned;
    logic                  reqLive;    // New access visible this cycle
    logic                  goodReq;
    logic                  badReq;
    bankIdxT               reqBank;
    logic [`WORD_BITS-1:0] reqWord;
    logic                  pending;    // Access in flight until response ends
    logic                  respStage;  // Response cycle on the bus
    logic [`NUM_BANKS-1:0] enVec;      // Bank enables for the check below

    assign offset  = wbReq.adr - `MEM_BASE;      // Wraps for addresses below base
    assign inRange = offset < `MEM_BYTES;        // Covers both ends of the window
    assign aligned = wbReq.adr[1:0] == 2'b00;    // Word accesses only
    assign reqLive = wbReq.cyc && wbReq.stb && !pending;
    assign goodReq = reqLive && inRange && aligned;
    assign badReq  = reqLive && !(inRange && aligned);

    // Low word bits pick the bank, the bits above pick the word
    assign reqBank = offset[`BANK_BITS+1:2];
    assign reqWord = offset[`WORD_BITS+`BANK_BITS+1:`BANK_BITS+2];

    // Fan the request out, enable only the addressed bank
    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            bankReq[b].en       = goodReq && (reqBank == bankIdxT'(b));
            bankReq[b].we       = bankReq[b].en && wbReq.we;  // No write without en
            bankReq[b].wordAddr = reqWord;
            bankReq[b].data     = wbReq.dat;
            bankReq[b].sel      = wbReq.sel;
            enVec[b]            = bankReq[b].en;
        end
    end

    // Access sequencing
    // Pending covers the accept edge up to the edge where the master sees the response
    always_ff @(posedge clk) begin
        if (rst) begin
            accepted   <= 1'b0;
            errPending <= 1'b0;
            respStage  <= 1'b0;
            pending    <= 1'b0;
        end else begin
            accepted   <= goodReq;                   // One pulse per good access
            errPending <= badReq;                    // One pulse per bad access
            respStage  <= accepted || errPending;    // Matches ack/err on the bus
            if (reqLive) begin
                pending <= 1'b1;                     // Block the held stb
            end else if (respStage) begin
                pending <= 1'b0;                     // Master has seen the response
            end
        end
    end

    // Bank number for the read return mux
    always_ff @(posedge clk) begin
        if (reqLive) begin
            bankSel <= reqBank;
        end
    end

    // Good and bad pulses exclude each other
    assert property (@(posedge clk) disable iff (rst) !(accepted && errPending))
        else $error("decoder: accepted and errPending together");

    // At most one bank active per cycle
    assert property (@(posedge clk) disable iff (rst) $onehot0(enVec))
        else $error("decoder: more than one bank enabled");

    // No second access while the response is still on the bus
    assert property (@(posedge clk) disable iff (rst)
        (accepted || errPending) |-> !$past(accepted || errPending)
                                     && !$past(accepted || errPending, 2))
        else $error("decoder: access taken during response");

endmodule

// ==== verilog/ramBank.sv ====
`timescale 1ns/1ps
`include "memMap_consts.svh"

module ramBank import memPkg::*; (
    input  logic        clk,
    input  bankReqT     req,
    output logic [31:0] rd      // Valid one edge after en
);

    // Four byte lanes, one RAM each, so byte enables map to lane write enables
    for (genvar lane = 0; lane < `LANE_COUNT; lane++) begin : laneGen
        logic [7:0] laneMem [`BANK_WORDS];  // Byte storage for this lane
        logic [7:0] laneRd;                 // Registered lane read
        logic       laneWe;                 // Write strobe for this lane

        // Storage starts cleared in simulation
        initial begin
            for (int w = 0; w < `BANK_WORDS; w++) begin
                laneMem[w] = 8'h00;
            end
        end

        assign laneWe = req.en && req.we && req.sel[lane];  // Masked by sel

        always_ff @(posedge clk) begin
            if (laneWe) begin
                laneMem[req.wordAddr] <= req.data[8*lane +: 8];
            end
            if (req.en) begin
                laneRd <= laneMem[req.wordAddr];  // Old data on a write
            end
        end

        assign rd[8*lane +: 8] = laneRd;  // Lane into its byte of the word
    end

    // Decoder only writes a bank that it has enabled
    assert property (@(posedge clk) req.we |-> req.en)
        else $error("ramBank: write enable without bank enable");

endmodule

// ==== verilog/readReturn.sv ====
`timescale 1ns/1ps
`include "memMap_consts.svh"

module readReturn import memPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        accepted,            // Good access, bank data valid now
    input  logic        errPending,          // Bad access, no bank touched
    input  bankIdxT     bankSel,             // Bank of that access
    input  logic [31:0] bankRd [`NUM_BANKS], // Read words of all banks
    output wbRspT       wbRsp
);

    logic        ackQ;
    logic        errQ;
    logic [31:0] datQ;

    // Response strobes follow the decoder pulses by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ackQ <= 1'b0;
            errQ <= 1'b0;
        end else begin
            ackQ <= accepted;
            errQ <= errPending;
        end
    end

    // Pick the addressed bank, zero otherwise
    always_ff @(posedge clk) begin
        datQ <= accepted ? bankRd[bankSel] : 32'h0000_0000;  // Err and idle give zero
    end

    assign wbRsp.ack = ackQ;
    assign wbRsp.err = errQ;
    assign wbRsp.dat = datQ;

    // One kind of termination per access
    assert property (@(posedge clk) disable iff (rst) !(wbRsp.ack && wbRsp.err))
        else $error("readReturn: ack and err together");

    // Error responses carry no bank data
    assert property (@(posedge clk) disable iff (rst) wbRsp.err |-> wbRsp.dat == 32'h0)
        else $error("readReturn: data on err");

endmodule

// ==== verilog/dataMemory.sv ====
`timescale 1ns/1ps
`include "memMap_consts.svh"

module dataMemory import memPkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  wbReqT wbReq,    // Wishbone classic slave port
    output wbRspT wbRsp
);

    bankReqT     bankReq [`NUM_BANKS];  // Decoder to banks
    logic [31:0] bankRd  [`NUM_BANKS];  // Banks to read return
    logic        accepted;
    logic        errPending;
    bankIdxT     bankSel;

    // Address check and bank select
    wbBankDecoder decoder_i (
        .clk        (clk),
        .rst        (rst),
        .wbReq      (wbReq),
        .bankReq    (bankReq),
        .accepted   (accepted),
        .errPending (errPending),
        .bankSel    (bankSel)
    );

    // Word-interleaved banks
    for (genvar b = 0; b < `NUM_BANKS; b++) begin : bankGen
        ramBank bank_i (
            .clk (clk),
            .req (bankReq[b]),
            .rd  (bankRd[b])
        );
    end

    // Response to the master
    readReturn readReturn_i (
        .clk        (clk),
        .rst        (rst),
        .accepted   (accepted),
        .errPending (errPending),
        .bankSel    (bankSel),
        .bankRd     (bankRd),
        .wbRsp      (wbRsp)
    );

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int HALF_PERIOD  = 5,   // ns, 10 ns clock
    parameter int RESET_CYCLES = 10   // Rising edges with rst high
) (
    output logic clk,
    output logic rst
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset drops on a falling edge, clear of the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== sim/dataMemoryTb.sv ====
`timescale 1ns/1ps

module dataMemoryTb import memPkg::*; ();

    localparam int          FIELDS        = 7;   // Words per case line
    localparam int          MAX_CASES     = 64;  // Room in the case table
    localparam int          RESET_CYCLES  = 10;
    localparam int          RESP_LIMIT    = 8;   // Cycles allowed for ack or err
    localparam int          RESP_EDGES    = 2;   // Accepting edge to response edge
    localparam int          ACCESS_CYCLES = 3;   // Drive, response, turnaround
    localparam int          MAX_GAP       = 3;   // Longest idle gap
    localparam int          MARGIN        = 20;
    localparam logic [1:0]  RSP_ERR       = 2'd2;
    localparam logic [31:0] SEED          = 32'h5132_c602;

    logic        clk;
    logic        rst;
    wbReqT       wbReq;                     // Master side of the bus
    wbRspT       wbRsp;
    logic [31:0] caseMem [FIELDS*MAX_CASES]; // Flat copy of the case file
    logic [31:0] lfsrState;
    int          numCases;
    int          cycleCount   = 0;
    int          timeoutLimit = 0;          // Zero until the cases are counted

    clockGen #(
        .RESET_CYCLES (RESET_CYCLES)
    ) clockGen_i (
        .clk (clk),
        .rst (rst)
    );

    dataMemory dut_i (
        .clk   (clk),
        .rst   (rst),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic fb;
        fb = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], fb};
    endfunction

    // Two LFSR bits give a gap of 0 to 3 cycles
    task automatic pickGap(output int gap);
        gap = 0;
        for (int i = 0; i < 2; i++) begin
            lfsrState = lfsrNext(lfsrState);        // One step per bit taken
            gap       = (gap << 1) | int'(lfsrState[0]);
        end
    endtask

    task automatic reportMismatch(input string caseName, input string what,
                                  input logic [31:0] expVal, input logic [31:0] actVal);
        $display("error: case %s %s expected %h actual %h", caseName, what, expVal, actVal);
        $display("RESULT: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // Bus quiet and data zero between responses
    task automatic checkIdle(input string where);
        assert (!wbRsp.ack && !wbRsp.err)
            else abortRun($sformatf("unexpected response on the idle bus after %s", where));
        assert (wbRsp.dat == 32'h0)
            else reportMismatch(where, "idle data", 32'h0, wbRsp.dat);
    endtask

    task automatic idleCycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            checkIdle("gap");
        end
    endtask

    // One Wishbone classic access, entered and left on a falling edge
    task automatic runCase(input int idx);
        int          base;
        int          waitCycles;
        logic        isWrite;
        logic [31:0] expData;
        logic [1:0]  expRsp;
        logic [1:0]  actRsp;
        string       name;
        base    = idx * FIELDS;
        isWrite = caseMem[base][0];
        expData = caseMem[base+4];
        expRsp  = caseMem[base+5][1:0];           // 1 ack, 2 err
        name    = $sformatf("%s", caseMem[base+6]); // Four ASCII chars
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = isWrite;
        wbReq.adr = caseMem[base+1];
        wbReq.dat = caseMem[base+3];
        wbReq.sel = caseMem[base+2][3:0];
        waitCycles = 0;
        do begin
            @(negedge clk);                       // Outputs settled since the last edge
            waitCycles++;
        end while (!wbRsp.ack && !wbRsp.err && waitCycles < RESP_LIMIT);
        assert (wbRsp.ack || wbRsp.err)
            else abortRun($sformatf("case %s got neither ack nor err within %0d cycles",
                                    name, RESP_LIMIT));
        assert (!(wbRsp.ack && wbRsp.err))
            else abortRun($sformatf("case %s saw ack and err together", name));
        assert (waitCycles == RESP_EDGES)
            else reportMismatch(name, "latency", 32'(RESP_EDGES), 32'(waitCycles));
        actRsp = {wbRsp.err, wbRsp.ack};
        assert (actRsp == expRsp)
            else reportMismatch(name, "response", 32'(expRsp), 32'(actRsp));
        if (!isWrite || expRsp == RSP_ERR) begin  // Write ack data is not part of the check
            assert (wbRsp.dat == expData)
                else reportMismatch(name, "read data", expData, wbRsp.dat);
        end
        @(negedge clk);                           // Master saw the response at the last edge
        checkIdle(name);                          // Exactly one response per access
        wbReq = '0;                               // Drop cyc and stb
    endtask

    // Cycle budget for the whole run
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("timeout: the run did not finish within %0d cycles", timeoutLimit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int gap;
        wbReq     = '0;                           // Bus idle through reset
        lfsrState = SEED;
        numCases  = 0;
        for (int i = 0; i < FIELDS*MAX_CASES; i++) begin
            caseMem[i] = '0;                      // Response code 0 ends the list
        end
        $readmemh("sim/memCases.hex", caseMem);
        while (numCases < MAX_CASES && caseMem[numCases*FIELDS+5] != 32'h0) begin
            numCases++;
        end
        assert (numCases > 0)
            else abortRun("no cases were read from sim/memCases.hex");
        timeoutLimit = numCases * (ACCESS_CYCLES + MAX_GAP) + RESET_CYCLES + MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        wait (!rst);
        @(negedge clk);
        checkIdle("reset");                       // Responses low out of reset

        for (int c = 0; c < numCases; c++) begin
            pickGap(gap);
            idleCycles(gap);
            runCase(c);
        end

        $display("checked %0d cases", numCases);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sim/memCases.hex ====
// Columns: write flag, byte address, sel, write data, expected read data,
// response (1 ack, 2 err), case name as four ASCII bytes

// Full words, last word of the window, never-written word
1 BFC00000 F 11223344 00000000 1 66773031
0 BFC00000 F 00000000 11223344 1 66773032
0 BFC00100 F 00000000 00000000 1 66773033
1 BFC03FFC F CAFEF00D 00000000 1 66773034
0 BFC03FFC F 00000000 CAFEF00D 1 66773035

// Byte lane merges with sel 0001, 0110, 1000
1 BFC00040 F A1B2C3D4 00000000 1 70773031
1 BFC00040 1 000000EE 00000000 1 70773032
0 BFC00040 F 00000000 A1B2C3EE 1 70773033
1 BFC00040 6 55667788 00000000 1 70773034
0 BFC00040 F 00000000 A16677EE 1 70773035
1 BFC00040 8 99000000 00000000 1 70773036
0 BFC00040 F 00000000 996677EE 1 70773037
1 BFC00044 6 FFFFFFFF 00000000 1 70773038
0 BFC00044 F 00000000 00FFFF00 1 70773039

// One word in each bank, then a second word in bank 0
1 BFC00200 F 0000B000 00000000 1 626B3031
1 BFC00204 F 0000B001 00000000 1 626B3032
1 BFC00208 F 0000B002 00000000 1 626B3033
1 BFC0020C F 0000B003 00000000 1 626B3034
0 BFC00200 F 00000000 0000B000 1 626B3035
0 BFC00204 F 00000000 0000B001 1 626B3036
0 BFC00208 F 00000000 0000B002 1 626B3037
0 BFC0020C F 00000000 0000B003 1 626B3038
1 BFC00210 F 0000B010 00000000 1 626B3039
0 BFC00200 F 00000000 0000B000 1 626B3130
0 BFC00210 F 00000000 0000B010 1 626B3131

// Below base, past the end, misaligned, then the aliased words unchanged
1 BFBFFFFC F DEADBEEF 00000000 2 65723031
0 BFBFFFFC F 00000000 00000000 2 65723032
1 BFC04000 F DEADBEEF 00000000 2 65723033
0 BFC00000 F 00000000 11223344 1 65723034
1 BFC00042 F DEADBEEF 00000000 2 65723035
0 BFC00040 F 00000000 996677EE 1 65723036
0 BFC00041 F 00000000 00000000 2 65723037
0 BFC04000 F 00000000 00000000 2 65723038
1 00000000 F DEADBEEF 00000000 2 65723039
0 FFFFFFFC F 00000000 00000000 2 65723130
0 BFC00000 F 00000000 11223344 1 65723131
0 BFC03FFC F 00000000 CAFEF00D 1 65723132

// Read-modify sequences on one word with random gaps
1 BFC0000C F 0BADCAFE 00000000 1 67703031
0 BFC0000C F 00000000 0BADCAFE 1 67703032
1 BFC0000C 3 0000FFFF 00000000 1 67703033
0 BFC0000C F 00000000 0BADFFFF 1 67703034
1 BFC0000C 3 00001234 00000000 1 67703035
0 BFC0000C F 00000000 0BAD1234 1 67703036
0 BFC00003 F 00000000 00000000 2 67703037
0 BFC0000C F 00000000 0BAD1234 1 67703038
0 BFC00208 F 00000000 0000B002 1 67703039

// ==== filelist.f ====
+incdir+verilog
verilog/memPkg.sv
verilog/wbBankDecoder.sv
verilog/ramBank.sv
verilog/readReturn.sv
verilog/dataMemory.sv
sim/clockGen.sv
sim/dataMemoryTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the data memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module dataMemoryTb -f filelist.f \
    -Mdir obj_dir -o dataMemorySim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/dataMemorySim | tee /dev/stderr | grep -qx "RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
